// File: mem_region.f
mem_region_pkg.sv
sp_ram.sv
ram_arbiter.sv
lsu_router.sv
ext_bridge.sv
host_port.sv
mem_region.sv
tb_mem_model.sv
tb_mem_region.sv

// File: Bender.yml
package:
  name: mem_region

sources:
  - mem_region_pkg.sv
  - sp_ram.sv
  - ram_arbiter.sv
  - lsu_router.sv
  - ext_bridge.sv
  - host_port.sv
  - mem_region.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_mem_region.sv

// File: tb_mem_region.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_region;

  import mem_region_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int USED_WORDS   = 32;
  localparam int CORE_WORDS   = 16;
  localparam int N_HOST_RAND  = 80;
  localparam int N_FETCH      = 60;
  localparam int N_LOCAL      = 60;
  localparam int N_EXT        = 30;
  localparam int N_MIXED      = 80;
  localparam int N_HOST_CONC  = 24;
  localparam int LOCAL_ONLY   = 0;
  localparam int EXT_ONLY     = 1;
  localparam int MIXED        = 2;

  // preload, first and last full checks, then every core and host phase
  localparam int N_TRANS = 6 * USED_WORDS + N_HOST_RAND + 2 * CORE_WORDS + 2 * N_FETCH
                           + N_LOCAL + N_EXT + 2 * N_MIXED + N_HOST_CONC;
  localparam int WORST_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = 2 * N_TRANS * WORST_CYCLES + RESET_CYCLES;

  typedef struct packed {
    logic         ext;
    logic         we;
    word_t        data;
    four_ph_req_t xreq;
  } exp_t;

  logic         clk;
  logic         rst_n;
  mem_req_t     fetch_req;
  mem_rsp_t     fetch_rsp;
  mem_req_t     lsu_req;
  mem_rsp_t     lsu_rsp;
  four_ph_req_t host_req;
  four_ph_rsp_t host_rsp;
  four_ph_req_t ext_req;
  four_ph_rsp_t ext_rsp;
  int           ext_checked;

  mem_region u_dut (
    .clk         ( clk       ),
    .rst_n       ( rst_n     ),
    .fetch_req_i ( fetch_req ),
    .fetch_rsp_o ( fetch_rsp ),
    .lsu_req_i   ( lsu_req   ),
    .lsu_rsp_o   ( lsu_rsp   ),
    .host_req_i  ( host_req  ),
    .host_rsp_o  ( host_rsp  ),
    .ext_req_o   ( ext_req   ),
    .ext_rsp_i   ( ext_rsp   )
  );

  tb_mem_model u_model (
    .clk       ( clk     ),
    .rst_n     ( rst_n   ),
    .ext_req_i ( ext_req ),
    .ext_rsp_o ( ext_rsp )
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("watchdog expired before the tests finished");
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected)
      stop_with_failure($sformatf("Error at %0t: %s data %h, expected %h",
                                  $time, what, actual, expected));
  endtask

  task automatic check_ext_req(input four_ph_req_t actual, input four_ph_req_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("Error at %0t: external request %h, expected %h",
                                  $time, actual, expected));
  endtask

  task automatic put_core_req(input bit lsu, input mem_req_t r);
    if (lsu)
      lsu_req = r;
    else
      fetch_req = r;
  endtask

  task automatic host_access(input bit bank, input ram_idx_t idx, input bit we,
                             input be_t be, input word_t wdata);
    lsu_addr_u a;
    word_t     expected;
    a       = '0;
    a.f.idx = idx;
    a.flat[HOST_BANK_BIT] = bank;
    @(posedge clk);
    #DRIVE_DELAY;
    host_req = '{req: 1'b1, we: we, be: be, addr: a.flat, wdata: wdata};
    do
    begin
      @(negedge clk);
    end
    while (!host_rsp.ack);
    if (we && bank)
      u_model.data_mem[idx] = u_model.merge_bytes(u_model.data_mem[idx], wdata, be);
    else if (we)
      u_model.instr_mem[idx] = u_model.merge_bytes(u_model.instr_mem[idx], wdata, be);
    else
    begin
      expected = bank ? u_model.data_mem[idx] : u_model.instr_mem[idx];
      check_word(host_rsp.rdata, expected, "host read");
    end
    @(posedge clk);
    #DRIVE_DELAY;
    host_req.req = 1'b0;
    do
    begin
      @(negedge clk);
    end
    while (host_rsp.ack);
  endtask

  task automatic host_random(input int n, input int lo, input int hi);
    for (int i = 0; i < n; i++)
    begin
      host_access($urandom_range(1) == 1, ram_idx_t'($urandom_range(hi, lo)),
                  $urandom_range(1) == 1, be_t'($urandom), $urandom);
    end
  endtask

  task automatic check_bank(input bit bank, input int lo, input int hi);
    for (int i = lo; i <= hi; i++)
    begin
      host_access(bank, ram_idx_t'(i), 1'b0, '0, '0);
    end
  endtask

  function automatic mem_req_t random_core_req(input bit lsu, input int mode);
    mem_req_t  r;
    lsu_addr_u a;
    bit        local_acc;
    a.flat     = $urandom;
    a.f.idx    = ram_idx_t'($urandom_range(CORE_WORDS - 1));
    a.f.offset = 2'b00;
    local_acc  = (mode == LOCAL_ONLY) || (mode == MIXED && $urandom_range(1) == 1);
    if (lsu && local_acc)
      a.f.region = LOCAL_REGION;
    else if (lsu)
    begin
      // a few external regions, so reads hit earlier writes
      a.f.region = 12'h100 + 12'($urandom_range(3));
      a.f.unused = '0;
    end
    r.req   = 1'b1;
    r.we    = ($urandom_range(1) == 1);
    r.be    = be_t'($urandom);
    r.addr  = a.flat;
    r.wdata = $urandom;
    return r;
  endfunction

  // one core port, n accesses, responses checked in grant order
  task automatic drive_core(input bit lsu, input int n, input int mode);
    mem_req_t  cur;
    mem_rsp_t  rsp;
    lsu_addr_u a;
    exp_t      exp_q[$];
    exp_t      e;
    int        issued;
    int        done;
    int        ext_open;
    bit        ext_was_open;
    bit        local_due;
    issued    = 0;
    done      = 0;
    ext_open  = 0;
    local_due = 1'b0;
    cur       = '0;
    while (done < n)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (!cur.req && issued < n && $urandom_range(3) != 0)
        cur = random_core_req(lsu, mode);
      put_core_req(lsu, cur);
      @(negedge clk);
      rsp          = lsu ? lsu_rsp : fetch_rsp;
      ext_was_open = (ext_open != 0);
      // bank accesses answer exactly one cycle after their grant
      if (local_due && !rsp.rvalid)
        stop_with_failure("local access did not complete one cycle after its grant");
      local_due = 1'b0;
      if (rsp.rvalid)
      begin
        if (exp_q.size() == 0)
          stop_with_failure("rvalid came with no granted access outstanding");
        e = exp_q.pop_front();
        if (e.ext)
        begin
          ext_open--;
          ext_checked++;
          if (u_model.ext_count != ext_checked)
            stop_with_failure("external access completed without exactly one bus transfer");
          check_ext_req(u_model.last_req, e.xreq);
        end
        if (!e.we)
          check_word(rsp.rdata, e.data, lsu ? "load" : "fetch");
        done++;
      end
      if (cur.req && rsp.gnt)
      begin
        if (ext_was_open)
          stop_with_failure("load/store grant given while an external access was pending");
        a      = cur.addr;
        e      = '0;
        e.we   = cur.we;
        e.ext  = lsu && (a.f.region != LOCAL_REGION);
        e.xreq = '{req: 1'b1, we: cur.we, be: cur.be, addr: cur.addr, wdata: cur.wdata};
        if (!lsu)
          e.data = u_model.instr_mem[a.f.idx];
        else if (e.ext)
        begin
          e.data = u_model.ext_read(cur.addr);
          ext_open++;
        end
        else if (cur.we)
          u_model.data_mem[a.f.idx] = u_model.merge_bytes(u_model.data_mem[a.f.idx],
                                                          cur.wdata, cur.be);
        else
          e.data = u_model.data_mem[a.f.idx];
        exp_q.push_back(e);
        local_due = !e.ext;
        issued++;
        cur.req = 1'b0;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    put_core_req(lsu, '0);
    @(negedge clk);
    rsp = lsu ? lsu_rsp : fetch_rsp;
    if (rsp.rvalid)
      stop_with_failure("more rvalid pulses than grants on a core port");
  endtask

  initial
  begin
    int unsigned seed;
    seed = 67;
    void'($urandom(seed));
    rst_n       = 1'b0;
    fetch_req   = '0;
    lsu_req     = '0;
    host_req    = '0;
    ext_checked = 0;
    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
    end
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // known contents in every word the tests touch
    for (int i = 0; i < USED_WORDS; i++)
    begin
      host_access(1'b0, ram_idx_t'(i), 1'b1, '1, $urandom);
      host_access(1'b1, ram_idx_t'(i), 1'b1, '1, $urandom);
    end
    host_random(N_HOST_RAND, 0, USED_WORDS - 1);
    check_bank(1'b0, 0, USED_WORDS - 1);
    check_bank(1'b1, 0, USED_WORDS - 1);

    drive_core(1'b0, N_FETCH, MIXED);
    check_bank(1'b0, 0, CORE_WORDS - 1);
    drive_core(1'b1, N_LOCAL, LOCAL_ONLY);
    check_bank(1'b1, 0, CORE_WORDS - 1);
    drive_core(1'b1, N_EXT, EXT_ONLY);
    drive_core(1'b1, N_MIXED, MIXED);

    // host works on its own words while both core ports run
    fork
      drive_core(1'b0, N_FETCH, MIXED);
      drive_core(1'b1, N_MIXED, MIXED);
      host_random(N_HOST_CONC, CORE_WORDS, USED_WORDS - 1);
    join

    check_bank(1'b0, 0, USED_WORDS - 1);
    check_bank(1'b1, 0, USED_WORDS - 1);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire mem_region_pkg::four_ph_req_t ext_req_i,
  output mem_region_pkg::four_ph_rsp_t     ext_rsp_o
);

  import mem_region_pkg::*;

  localparam int DRIVE_DELAY = 10;

  word_t        instr_mem [NUM_WORDS];
  word_t        data_mem  [NUM_WORDS];
  word_t        ext_mem   [addr_t];
  four_ph_req_t last_req;
  int           ext_count;

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input be_t be);
    word_t w;
    w = old_word;
    for (int b = 0; b < BE_WIDTH; b++)
    begin
      if (be[b])
      begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  // locations never written answer with a pattern of the whole address
  function automatic word_t ext_read(input addr_t addr);
    word_t w;
    if (ext_mem.exists(addr))
    begin
      w = ext_mem[addr];
    end
    else
    begin
      w = addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    end
    return w;
  endfunction

  // external slave, ack after 1 to 6 cycles
  initial
  begin
    int unsigned delay;
    ext_rsp_o = '0;
    last_req  = '0;
    ext_count = 0;
    forever
    begin
      @(negedge clk);
      if (rst_n && ext_req_i.req && !ext_rsp_o.ack)
      begin
        last_req = ext_req_i;
        ext_count++;
        delay = $urandom_range(6, 1);
        repeat (delay)
        begin
          @(posedge clk);
        end
        #DRIVE_DELAY;
        ext_rsp_o.rdata = ext_read(last_req.addr);
        if (last_req.we)
        begin
          ext_mem[last_req.addr] = merge_bytes(ext_read(last_req.addr), last_req.wdata,
                                               last_req.be);
        end
        ext_rsp_o.ack = 1'b1;
        do
        begin
          @(negedge clk);
        end
        while (ext_req_i.req);
        @(posedge clk);
        #DRIVE_DELAY;
        ext_rsp_o.ack = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: mem_region.sv
`timescale 1ns/100ps
`default_nettype none

module mem_region (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire mem_region_pkg::mem_req_t     fetch_req_i,
  output mem_region_pkg::mem_rsp_t         fetch_rsp_o,
  input  wire mem_region_pkg::mem_req_t     lsu_req_i,
  output mem_region_pkg::mem_rsp_t         lsu_rsp_o,
  input  wire mem_region_pkg::four_ph_req_t host_req_i,
  output mem_region_pkg::four_ph_rsp_t     host_rsp_o,
  output mem_region_pkg::four_ph_req_t     ext_req_o,
  input  wire mem_region_pkg::four_ph_rsp_t ext_rsp_i
);

  import mem_region_pkg::*;

  ram_cmd_t instr_host_cmd;
  ram_cmd_t data_host_cmd;
  word_t    instr_host_rdata;
  word_t    data_host_rdata;
  mem_req_t data_req;
  mem_rsp_t data_rsp;
  mem_req_t ext_core_req;
  mem_rsp_t ext_core_rsp;

  host_port u_host_port (
    .clk           ( clk              ),
    .rst_n         ( rst_n            ),
    .host_req_i    ( host_req_i       ),
    .host_rsp_o    ( host_rsp_o       ),
    .instr_cmd_o   ( instr_host_cmd   ),
    .instr_rdata_i ( instr_host_rdata ),
    .data_cmd_o    ( data_host_cmd    ),
    .data_rdata_i  ( data_host_rdata  )
  );

  // fetch port never writes the instruction bank
  ram_arbiter #(
    .CORE_READ_ONLY ( 1'b1 )
  ) instr_arb (
    .clk          ( clk              ),
    .rst_n        ( rst_n            ),
    .host_cmd_i   ( instr_host_cmd   ),
    .host_rdata_o ( instr_host_rdata ),
    .core_req_i   ( fetch_req_i      ),
    .core_rsp_o   ( fetch_rsp_o      )
  );

  ram_arbiter #(
    .CORE_READ_ONLY ( 1'b0 )
  ) data_arb (
    .clk          ( clk             ),
    .rst_n        ( rst_n           ),
    .host_cmd_i   ( data_host_cmd   ),
    .host_rdata_o ( data_host_rdata ),
    .core_req_i   ( data_req        ),
    .core_rsp_o   ( data_rsp        )
  );

  lsu_router u_lsu_router (
    .clk        ( clk          ),
    .rst_n      ( rst_n        ),
    .lsu_req_i  ( lsu_req_i    ),
    .lsu_rsp_o  ( lsu_rsp_o    ),
    .data_req_o ( data_req     ),
    .data_rsp_i ( data_rsp     ),
    .ext_req_o  ( ext_core_req ),
    .ext_rsp_i  ( ext_core_rsp )
  );

  ext_bridge u_ext_bridge (
    .clk        ( clk          ),
    .rst_n      ( rst_n        ),
    .core_req_i ( ext_core_req ),
    .core_rsp_o ( ext_core_rsp ),
    .bus_req_o  ( ext_req_o    ),
    .bus_rsp_i  ( ext_rsp_i    )
  );

endmodule

`default_nettype wire

// File: host_port.sv
`timescale 1ns/100ps
`default_nettype none

module host_port (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire mem_region_pkg::four_ph_req_t host_req_i,
  output mem_region_pkg::four_ph_rsp_t     host_rsp_o,
  output mem_region_pkg::ram_cmd_t         instr_cmd_o,
  input  wire mem_region_pkg::word_t        instr_rdata_i,
  output mem_region_pkg::ram_cmd_t         data_cmd_o,
  input  wire mem_region_pkg::word_t        data_rdata_i
);

  import mem_region_pkg::*;

  lsu_addr_u host_addr;
  ram_cmd_t  cmd_q;
  logic      bank_q;
  logic      busy_q;
  logic      en_q;
  logic      rd_pending_q;
  logic      ack_q;
  word_t     rdata_q;
  logic      accept;

  assign host_addr = host_req_i.addr;
  assign accept    = host_req_i.req & ~busy_q;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q  <= '{en: 1'b1, we: host_req_i.we, be: host_req_i.be,
                  idx: host_addr.f.idx, wdata: host_req_i.wdata};
      bank_q <= host_addr.flat[HOST_BANK_BIT];
    end
    if (rd_pending_q)
    begin
      rdata_q <= bank_q ? data_rdata_i : instr_rdata_i;
    end
  end

  // command, then read word, then ack
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q       <= 1'b0;
      en_q         <= 1'b0;
      rd_pending_q <= 1'b0;
      ack_q        <= 1'b0;
    end
    else
    begin
      en_q         <= accept;
      rd_pending_q <= en_q;
      if (accept)
      begin
        busy_q <= 1'b1;
      end
      if (rd_pending_q)
      begin
        ack_q <= 1'b1;
      end
      else if (ack_q && !host_req_i.req)
      begin
        ack_q  <= 1'b0;
        busy_q <= 1'b0;
      end
    end
  end

  always_comb
  begin
    instr_cmd_o    = cmd_q;
    instr_cmd_o.en = en_q & ~bank_q;
    data_cmd_o     = cmd_q;
    data_cmd_o.en  = en_q & bank_q;
  end

  assign host_rsp_o.ack   = ack_q;
  assign host_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: ext_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module ext_bridge (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire mem_region_pkg::mem_req_t     core_req_i,
  output mem_region_pkg::mem_rsp_t         core_rsp_o,
  output mem_region_pkg::four_ph_req_t     bus_req_o,
  input  wire mem_region_pkg::four_ph_rsp_t bus_rsp_i
);

  import mem_region_pkg::*;

  typedef enum logic [1:0] { IDLE, REQUEST, RELEASE, RESPOND } state_e;

  state_e state_q;
  state_e state_d;
  logic   accept;
  logic   we_q;
  be_t    be_q;
  addr_t  addr_q;
  word_t  wdata_q;
  word_t  rdata_q;

  assign accept = (state_q == IDLE) & core_req_i.req;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (core_req_i.req)
          state_d = REQUEST;
      REQUEST:
        if (bus_rsp_i.ack)
          state_d = RELEASE;
      // wait for the slave to drop ack
      RELEASE:
        if (!bus_rsp_i.ack)
          state_d = RESPOND;
      RESPOND:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      we_q    <= core_req_i.we;
      be_q    <= core_req_i.be;
      addr_q  <= core_req_i.addr;
      wdata_q <= core_req_i.wdata;
    end
    if (state_q == REQUEST && bus_rsp_i.ack)
    begin
      rdata_q <= bus_rsp_i.rdata;
    end
  end

  assign bus_req_o.req   = (state_q == REQUEST);
  assign bus_req_o.we    = we_q;
  assign bus_req_o.be    = be_q;
  assign bus_req_o.addr  = addr_q;
  assign bus_req_o.wdata = wdata_q;

  assign core_rsp_o.gnt    = accept;
  assign core_rsp_o.rvalid = (state_q == RESPOND);
  assign core_rsp_o.rdata  = rdata_q;

  ap_payload_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_req_o.req && !bus_rsp_i.ack |=> $stable(bus_req_o)
  );

  ap_req_after_ack_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(bus_req_o.req) |-> !bus_rsp_i.ack
  );

endmodule

`default_nettype wire

// File: lsu_router.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_router (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire mem_region_pkg::mem_req_t lsu_req_i,
  output mem_region_pkg::mem_rsp_t     lsu_rsp_o,
  output mem_region_pkg::mem_req_t     data_req_o,
  input  wire mem_region_pkg::mem_rsp_t data_rsp_i,
  output mem_region_pkg::mem_req_t     ext_req_o,
  input  wire mem_region_pkg::mem_rsp_t ext_rsp_i
);

  import mem_region_pkg::*;

  lsu_addr_u lsu_addr;
  logic      is_local;
  logic      lsu_gnt;
  logic      target_ext_q;
  logic      ext_pending_q;

  assign lsu_addr = lsu_req_i.addr;
  assign is_local = (lsu_addr.f.region == LOCAL_REGION);

  // nothing new goes out while an external access is open
  always_comb
  begin
    data_req_o     = lsu_req_i;
    data_req_o.req = lsu_req_i.req & is_local & ~ext_pending_q;

    ext_req_o      = lsu_req_i;
    ext_req_o.addr = lsu_addr.flat;
    ext_req_o.req  = lsu_req_i.req & ~is_local & ~ext_pending_q;
  end

  assign lsu_gnt = is_local ? data_rsp_i.gnt : ext_rsp_i.gnt;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      target_ext_q  <= 1'b0;
      ext_pending_q <= 1'b0;
    end
    else
    begin
      // next response comes from wherever this grant went
      if (lsu_gnt)
      begin
        target_ext_q <= ~is_local;
      end
      if (lsu_gnt && !is_local)
      begin
        ext_pending_q <= 1'b1;
      end
      else if (ext_rsp_i.rvalid)
      begin
        ext_pending_q <= 1'b0;
      end
    end
  end

  assign lsu_rsp_o.gnt    = lsu_gnt;
  assign lsu_rsp_o.rvalid = target_ext_q ? ext_rsp_i.rvalid : data_rsp_i.rvalid;
  assign lsu_rsp_o.rdata  = target_ext_q ? ext_rsp_i.rdata : data_rsp_i.rdata;

  ap_no_gnt_while_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    ext_pending_q |-> !lsu_rsp_o.gnt
  );

  ap_single_responder: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(data_rsp_i.rvalid && ext_rsp_i.rvalid)
  );

endmodule

`default_nettype wire

// File: ram_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module ram_arbiter #(
  parameter bit CORE_READ_ONLY = 1'b0
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire mem_region_pkg::ram_cmd_t host_cmd_i,
  output mem_region_pkg::word_t        host_rdata_o,
  input  wire mem_region_pkg::mem_req_t core_req_i,
  output mem_region_pkg::mem_rsp_t     core_rsp_o
);

  import mem_region_pkg::*;

  lsu_addr_u core_addr;
  ram_cmd_t  ram_cmd;
  word_t     ram_rdata;
  logic      core_gnt;
  logic      core_rvalid_q;

  assign core_addr = core_req_i.addr;

  // host always wins the bank
  assign core_gnt = core_req_i.req & ~host_cmd_i.en;

  always_comb
  begin
    ram_cmd = host_cmd_i;
    if (!host_cmd_i.en)
    begin
      ram_cmd.en    = core_req_i.req;
      ram_cmd.we    = core_req_i.we & ~CORE_READ_ONLY;
      ram_cmd.be    = core_req_i.be;
      ram_cmd.idx   = core_addr.f.idx;
      ram_cmd.wdata = core_req_i.wdata;
    end
  end

  sp_ram u_ram (
    .clk     ( clk       ),
    .cmd_i   ( ram_cmd   ),
    .rdata_o ( ram_rdata )
  );

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      core_rvalid_q <= 1'b0;
    end
    else
    begin
      core_rvalid_q <= core_gnt;
    end
  end

  // both sides see the same read word, one cycle after their access
  assign host_rdata_o      = ram_rdata;
  assign core_rsp_o.gnt    = core_gnt;
  assign core_rsp_o.rvalid = core_rvalid_q;
  assign core_rsp_o.rdata  = ram_rdata;

  ap_rvalid_after_gnt: assert property (
    @(posedge clk) disable iff (!rst_n)
    core_rsp_o.gnt |=> core_rsp_o.rvalid
  );

  ap_rvalid_only_after_gnt: assert property (
    @(posedge clk) disable iff (!rst_n)
    core_rsp_o.rvalid |-> $past(core_rsp_o.gnt)
  );

  ap_no_gnt_under_host: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(core_rsp_o.gnt && host_cmd_i.en)
  );

endmodule

`default_nettype wire

// File: sp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sp_ram (
  input  wire                          clk,
  input  wire mem_region_pkg::ram_cmd_t cmd_i,
  output mem_region_pkg::word_t        rdata_o
);

  import mem_region_pkg::*;

  word_t mem [NUM_WORDS];

  // byte lanes written individually
  always_ff @(posedge clk)
  begin
    if (cmd_i.en && cmd_i.we)
    begin
      for (int b = 0; b < BE_WIDTH; b++)
      begin
        if (cmd_i.be[b])
        begin
          mem[cmd_i.idx][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read word registered, held until the next read
  always_ff @(posedge clk)
  begin
    if (cmd_i.en && !cmd_i.we)
    begin
      rdata_o <= mem[cmd_i.idx];
    end
  end

endmodule

`default_nettype wire

// File: mem_region_pkg.sv
`default_nettype none

package mem_region_pkg;

  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned BE_WIDTH       = DATA_WIDTH / 8;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned RAM_ADDR_WIDTH = 10;
  localparam int unsigned NUM_WORDS      = 2 ** RAM_ADDR_WIDTH;

  // address bits 31:20 tag the local data region
  localparam logic [11:0] LOCAL_REGION  = 12'h001;
  localparam int unsigned HOST_BANK_BIT = 12;

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [BE_WIDTH-1:0]       be_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [RAM_ADDR_WIDTH-1:0] ram_idx_t;

  // one address word, seen flat or split into fields
  typedef union packed {
    addr_t flat;
    struct packed {
      logic [11:0]                            region;
      logic [ADDR_WIDTH-12-RAM_ADDR_WIDTH-3:0] unused;
      ram_idx_t                               idx;
      logic [1:0]                             offset;
    } f;
  } lsu_addr_u;

  // core side, req/gnt/rvalid
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic     en;
    logic     we;
    be_t      be;
    ram_idx_t idx;
    word_t    wdata;
  } ram_cmd_t;

  // four-phase req/ack, host port and external bus
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
  } four_ph_req_t;

  typedef struct packed {
    logic  ack;
    word_t rdata;
  } four_ph_rsp_t;

endpackage

`default_nettype wire
